//--- hdl/rc4_pkg.sv
package rc4_pkg;

	localparam int KEY_W = 24; // three key bytes, msb used first
	localparam int SBOX_DEPTH = 256; // rc4 state size

	typedef logic [7:0] byte_t; // one data byte
	typedef logic [KEY_W-1:0] key_t; // candidate key

	// controller phases, one key in flight at a time
	typedef enum logic [2:0] {
		idle, // waiting for start
		init_sbox, // identity fill
		schedule, // ksa swaps
		decrypt, // prga running
		judge, // one byte under test
		next_key, // step key or give up
		found, // key accepted
		exhausted // nothing in range
	} search_phase_t;

	// printable test: a to z or space
	function automatic logic char_ok(input byte_t b);
		return ((b >= 8'd97) && (b <= 8'd122)) || (b == 8'd32);
	endfunction

endpackage

//--- hdl/byte_ram.sv
`timescale 1ns/1ns

// single-port byte store, old data returned on a write cycle
module byte_ram
	import rc4_pkg::*;
#(
	parameter int DEPTH = SBOX_DEPTH // entries
)(
	input  logic                     clok,
	input  logic                     we, // write strobe
	input  logic [$clog2(DEPTH)-1:0] addr, // shared read/write address
	input  byte_t                    wdata,
	output byte_t                    rdata // valid one cycle after addr
);

	byte_t mem [DEPTH]; // storage, no reset

	// read-first: a swap can write S[j] and fetch its old value together
	always_ff @(posedge clok) begin
		if (we) begin
			mem[addr] <= wdata; // write port
		end
		rdata <= mem[addr]; // registered read, old contents
	end

endmodule

//--- hdl/sbox_init.sv
`timescale 1ns/1ns

// fills S[n] = n, one entry per cycle
module sbox_init
	import rc4_pkg::*;
(
	input  logic  clok,
	input  logic  resetm,
	input  logic  go, // start fill
	output logic  done, // one cycle after last write
	output byte_t s_addr,
	output logic  s_we,
	output byte_t s_wdata
);

	logic  active; // fill in progress
	byte_t cnt; // entry index

	assign s_we = active;
	assign s_addr = cnt;
	assign s_wdata = cnt; // identity value

	always_ff @(posedge clok or negedge resetm) begin
		if (!resetm) begin
			active <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0; // pulse only
			if (go) begin
				active <= 1'b1;
				cnt <= '0;
			end else if (active) begin
				cnt <= cnt + 8'd1; // wraps to 0 after 255
				if (cnt == 8'hff) begin
					active <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// a fill burst always follows a go
	assert property (@(posedge clok) disable iff (!resetm) $rose(s_we) |-> $past(go));

endmodule

//--- hdl/key_schedule.sv
`timescale 1ns/1ns

// rc4 ksa, three cycles per i: read S[i], swap-write S[j], write S[i]
module key_schedule
	import rc4_pkg::*;
(
	input  logic  clok,
	input  logic  resetm,
	input  logic  go, // start schedule
	input  key_t  key, // candidate key
	output logic  done, // after i = 255 swap
	output byte_t s_addr,
	output logic  s_we,
	output byte_t s_wdata,
	input  byte_t s_rdata
);

	typedef enum logic [1:0] {ks_idle, ks_read_i, ks_swap_j, ks_write_i} ks_state_t;

	ks_state_t  state;
	byte_t      i; // step index
	byte_t      j; // running sum
	logic [1:0] kidx; // i mod 3
	byte_t      kbyte; // key byte for this step
	byte_t      j_next;

	always_comb begin
		case (kidx)
			2'd0:    kbyte = key[KEY_W-1 -: 8]; // msb first
			2'd1:    kbyte = key[KEY_W-9 -: 8];
			default: kbyte = key[7:0];
		endcase
	end

	assign j_next = j + s_rdata + kbyte; // s_rdata holds S[i] in ks_swap_j

	// S[j] takes S[i] while its old value is read back; that value lands in S[i]
	always_comb begin
		s_addr = i;
		s_we = 1'b0;
		s_wdata = s_rdata; // forwarded straight from the read
		case (state)
			ks_swap_j: begin
				s_addr = j_next;
				s_we = 1'b1;
			end
			ks_write_i: s_we = 1'b1; // rdata now old S[j]
			default: ;
		endcase
	end

	always_ff @(posedge clok or negedge resetm) begin
		if (!resetm) begin
			state <= ks_idle;
			i <= '0;
			j <= '0;
			kidx <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ks_idle: if (go) begin
					i <= '0;
					j <= '0;
					kidx <= '0;
					state <= ks_read_i;
				end
				ks_read_i: state <= ks_swap_j;
				ks_swap_j: begin
					j <= j_next; // keep new j
					state <= ks_write_i;
				end
				ks_write_i: begin
					i <= i + 8'd1;
					kidx <= (kidx == 2'd2) ? 2'd0 : kidx + 2'd1;
					if (i == 8'hff) begin
						done <= 1'b1;
						state <= ks_idle;
					end else begin
						state <= ks_read_i;
					end
				end
				default: state <= ks_idle;
			endcase
		end
	end

	// the last swap write finishes before done reaches the controller
	assert property (@(posedge clok) disable iff (!resetm) !(done && s_we));

endmodule

//--- hdl/stream_decrypt.sv
`timescale 1ns/1ns

// rc4 prga, four cycles per byte then a wait for the controller's verdict
module stream_decrypt
	import rc4_pkg::*;
#(
	parameter int MSG_LEN = 32 // bytes per message
)(
	input  logic                       clok,
	input  logic                       resetm,
	input  logic                       go, // start a message
	input  logic                       abort, // bad byte, drop key
	input  logic                       char_next, // byte accepted
	output byte_t                      s_addr,
	output logic                       s_we,
	output byte_t                      s_wdata,
	input  byte_t                      s_rdata,
	output logic [$clog2(MSG_LEN)-1:0] ct_addr,
	input  byte_t                      ct_rdata,
	output logic                       pt_we,
	output logic [$clog2(MSG_LEN)-1:0] pt_addr,
	output byte_t                      pt_wdata,
	output logic                       char_valid, // new plaintext byte
	output byte_t                      char_byte,
	output logic                       done // last byte accepted
);

	localparam int MA = $clog2(MSG_LEN);

	typedef enum logic [2:0] {
		d_idle, d_read_i, d_swap_j, d_read_t, d_write_i, d_wait
	} dec_state_t;

	dec_state_t    state;
	byte_t         i; // prga i
	byte_t         j; // prga j
	byte_t         si_q; // S[i] before swap
	byte_t         sj_q; // S[j] before swap
	logic          fwd_q; // t hit i, S[i] not yet rewritten
	logic [MA-1:0] k; // message byte index
	byte_t         j_next;
	byte_t         t_idx; // S[i] + S[j]
	byte_t         ks_byte; // keystream

	assign j_next = j + s_rdata;
	assign t_idx = si_q + s_rdata; // s_rdata is old S[j] in d_read_t
	assign ks_byte = fwd_q ? sj_q : s_rdata;
	assign char_byte = ks_byte ^ ct_rdata;
	assign char_valid = (state == d_write_i);
	assign pt_we = char_valid; // plaintext written with each verdict request
	assign pt_addr = k;
	assign pt_wdata = char_byte;
	assign ct_addr = k; // ct settled long before d_write_i

	always_comb begin
		s_addr = i;
		s_we = 1'b0;
		s_wdata = sj_q; // S[i] gets old S[j]
		case (state)
			d_swap_j: begin
				s_addr = j_next; // write S[j] = S[i], fetch old S[j]
				s_we = 1'b1;
				s_wdata = s_rdata;
			end
			d_read_t: s_addr = t_idx; // keystream read
			d_write_i: s_we = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clok) begin
		if (state == d_swap_j) begin
			si_q <= s_rdata;
		end
		if (state == d_read_t) begin
			sj_q <= s_rdata;
			fwd_q <= (t_idx == i);
		end
	end

	always_ff @(posedge clok or negedge resetm) begin
		if (!resetm) begin
			state <= d_idle;
			i <= '0;
			j <= '0;
			k <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (abort) begin
				state <= d_idle; // key dropped mid message
			end else begin
				case (state)
					d_idle: if (go) begin
						i <= 8'd1; // prga pre-increments i
						j <= '0;
						k <= '0;
						state <= d_read_i;
					end
					d_read_i: state <= d_swap_j;
					d_swap_j: begin
						j <= j_next;
						state <= d_read_t;
					end
					d_read_t: state <= d_write_i;
					d_write_i: state <= d_wait;
					d_wait: if (char_next) begin
						if (k == MA'(MSG_LEN - 1)) begin
							done <= 1'b1;
							state <= d_idle;
						end else begin
							k <= k + 1'b1;
							i <= i + 8'd1;
							state <= d_read_i;
						end
					end
					default: state <= d_idle;
				endcase
			end
		end
	end

	// every byte waits for a verdict before the next one
	assert property (@(posedge clok) disable iff (!resetm) char_valid |=> !char_valid);

endmodule

//--- hdl/key_search_ctrl.sv
`timescale 1ns/1ns

// search sequencer for phases, s-box port, byte judge and key counter
module key_search_ctrl
	import rc4_pkg::*;
#(
	parameter int          MSG_LEN = 32,
	parameter int unsigned KEY_LIMIT = 2**22 // keys tried
)(
	input  logic                       clok,
	input  logic                       resetm,
	input  logic                       start, // one cycle pulse
	output logic                       init_go,
	output logic                       sched_go,
	output logic                       dec_go,
	input  logic                       init_done,
	input  logic                       sched_done,
	input  logic                       dec_done,
	input  byte_t                      init_s_addr,
	input  logic                       init_s_we,
	input  byte_t                      init_s_wdata,
	input  byte_t                      sched_s_addr,
	input  logic                       sched_s_we,
	input  byte_t                      sched_s_wdata,
	input  byte_t                      dec_s_addr,
	input  logic                       dec_s_we,
	input  byte_t                      dec_s_wdata,
	output byte_t                      s_addr, // to s-box ram
	output logic                       s_we,
	output byte_t                      s_wdata,
	input  logic                       char_valid,
	input  byte_t                      char_byte,
	output logic                       char_next,
	output logic                       abort,
	input  logic [$clog2(MSG_LEN)-1:0] pt_addr_ext, // host read address
	input  logic [$clog2(MSG_LEN)-1:0] pt_addr_dec, // decrypt write address
	output logic [$clog2(MSG_LEN)-1:0] pt_raddr,
	output key_t                       key,
	output logic                       busy,
	output logic                       found,
	output logic                       exhausted
);

	search_phase_t phase;
	byte_t         char_q; // byte under judgment
	logic          char_good;
	logic          dec_owns; // decrypt holds s-box and plaintext

	assign char_good = char_ok(char_q);
	assign char_next = (phase == judge) && char_good;
	assign abort = (phase == judge) && !char_good; // decrypt drops to idle
	assign dec_owns = (phase == decrypt) || (phase == judge);

	// status decoded from the phase so found rises as busy falls
	assign found = (phase == rc4_pkg::found);
	assign exhausted = (phase == rc4_pkg::exhausted);
	assign busy = !((phase == idle) || found || exhausted);

	assign pt_raddr = dec_owns ? pt_addr_dec : pt_addr_ext;

	always_comb begin
		s_addr = init_s_addr;
		s_we = 1'b0; // no writes outside a phase
		s_wdata = init_s_wdata;
		if (phase == init_sbox) begin
			s_we = init_s_we;
		end else if (phase == schedule) begin
			s_addr = sched_s_addr;
			s_we = sched_s_we;
			s_wdata = sched_s_wdata;
		end else if (dec_owns) begin
			s_addr = dec_s_addr;
			s_we = dec_s_we;
			s_wdata = dec_s_wdata;
		end
	end

	always_ff @(posedge clok) begin
		if ((phase == decrypt) && char_valid) begin
			char_q <= char_byte; // held for the judge cycle
		end
	end

	always_ff @(posedge clok or negedge resetm) begin
		if (!resetm) begin
			phase <= idle;
			key <= '0;
			init_go <= 1'b0;
			sched_go <= 1'b0;
			dec_go <= 1'b0;
		end else begin
			init_go <= 1'b0; // go strobes are pulses
			sched_go <= 1'b0;
			dec_go <= 1'b0;
			case (phase)
				idle, rc4_pkg::found, rc4_pkg::exhausted: if (start) begin
					key <= '0; // always search from zero
					init_go <= 1'b1;
					phase <= init_sbox;
				end
				init_sbox: if (init_done) begin
					sched_go <= 1'b1;
					phase <= schedule;
				end
				schedule: if (sched_done) begin
					dec_go <= 1'b1;
					phase <= decrypt;
				end
				decrypt: begin
					if (dec_done) begin
						phase <= rc4_pkg::found; // every byte passed
					end else if (char_valid) begin
						phase <= judge;
					end
				end
				judge: phase <= char_good ? decrypt : next_key;
				next_key: begin
					if (key == key_t'(KEY_LIMIT - 1)) begin
						phase <= rc4_pkg::exhausted;
					end else begin
						key <= key + 1'b1;
						init_go <= 1'b1; // restart with fresh s-box
						phase <= init_sbox;
					end
				end
				default: phase <= idle;
			endcase
		end
	end

	// verdict requests only while the decrypt phase listens
	assert property (@(posedge clok) disable iff (!resetm) char_valid |-> (phase == decrypt));
	assert property (@(posedge clok) disable iff (!resetm) key < KEY_LIMIT); // no run past range

endmodule

//--- hdl/rc4_cracker.sv
`timescale 1ns/1ns

// top level: key search controller, three rc4 blocks, three byte stores
module rc4_cracker
	import rc4_pkg::*;
#(
	parameter int          MSG_LEN = 32, // ciphertext bytes
	parameter int unsigned KEY_LIMIT = 2**22 // keys 0 .. KEY_LIMIT-1
)(
	input  logic                       clok,
	input  logic                       resetm,
	input  logic                       ct_we, // ciphertext load, idle only
	input  logic [$clog2(MSG_LEN)-1:0] ct_addr,
	input  byte_t                      ct_wdata,
	input  logic                       start,
	input  logic [$clog2(MSG_LEN)-1:0] pt_addr,
	output byte_t                      pt_rdata, // one cycle after pt_addr
	output logic                       busy,
	output logic                       found,
	output logic                       exhausted,
	output key_t                       key
);

	localparam int MA = $clog2(MSG_LEN);

	logic          init_go, sched_go, dec_go;
	logic          init_done, sched_done, dec_done;
	byte_t         init_s_addr, init_s_wdata;
	logic          init_s_we;
	byte_t         sched_s_addr, sched_s_wdata;
	logic          sched_s_we;
	byte_t         dec_s_addr, dec_s_wdata;
	logic          dec_s_we;
	byte_t         s_addr, s_wdata, s_rdata; // shared s-box port
	logic          s_we;
	logic          char_valid, char_next, abort;
	byte_t         char_byte;
	logic [MA-1:0] dec_ct_addr, ct_ram_addr;
	byte_t         ct_rdata;
	logic          ct_ram_we;
	logic          pt_we;
	logic [MA-1:0] pt_addr_dec, pt_raddr;
	byte_t         pt_wdata;

	assign ct_ram_we = ct_we & ~busy; // host loads ignored mid search
	assign ct_ram_addr = busy ? dec_ct_addr : ct_addr;

	key_search_ctrl #(.MSG_LEN(MSG_LEN), .KEY_LIMIT(KEY_LIMIT)) u_ctrl (
		.clok(clok), .resetm(resetm), .start(start),
		.init_go(init_go), .sched_go(sched_go), .dec_go(dec_go),
		.init_done(init_done), .sched_done(sched_done), .dec_done(dec_done),
		.init_s_addr(init_s_addr), .init_s_we(init_s_we), .init_s_wdata(init_s_wdata),
		.sched_s_addr(sched_s_addr), .sched_s_we(sched_s_we), .sched_s_wdata(sched_s_wdata),
		.dec_s_addr(dec_s_addr), .dec_s_we(dec_s_we), .dec_s_wdata(dec_s_wdata),
		.s_addr(s_addr), .s_we(s_we), .s_wdata(s_wdata),
		.char_valid(char_valid), .char_byte(char_byte),
		.char_next(char_next), .abort(abort),
		.pt_addr_ext(pt_addr), .pt_addr_dec(pt_addr_dec), .pt_raddr(pt_raddr),
		.key(key), .busy(busy), .found(found), .exhausted(exhausted)
	);

	sbox_init u_init (
		.clok(clok), .resetm(resetm), .go(init_go), .done(init_done),
		.s_addr(init_s_addr), .s_we(init_s_we), .s_wdata(init_s_wdata)
	);

	key_schedule u_sched (
		.clok(clok), .resetm(resetm), .go(sched_go), .key(key), .done(sched_done),
		.s_addr(sched_s_addr), .s_we(sched_s_we), .s_wdata(sched_s_wdata),
		.s_rdata(s_rdata)
	);

	stream_decrypt #(.MSG_LEN(MSG_LEN)) u_dec (
		.clok(clok), .resetm(resetm), .go(dec_go), .abort(abort),
		.char_next(char_next),
		.s_addr(dec_s_addr), .s_we(dec_s_we), .s_wdata(dec_s_wdata), .s_rdata(s_rdata),
		.ct_addr(dec_ct_addr), .ct_rdata(ct_rdata),
		.pt_we(pt_we), .pt_addr(pt_addr_dec), .pt_wdata(pt_wdata),
		.char_valid(char_valid), .char_byte(char_byte), .done(dec_done)
	);

	byte_ram #(.DEPTH(SBOX_DEPTH)) u_sbox (
		.clok(clok), .we(s_we), .addr(s_addr), .wdata(s_wdata), .rdata(s_rdata)
	);

	byte_ram #(.DEPTH(MSG_LEN)) u_ct_ram (
		.clok(clok), .we(ct_ram_we), .addr(ct_ram_addr), .wdata(ct_wdata),
		.rdata(ct_rdata)
	);

	byte_ram #(.DEPTH(MSG_LEN)) u_pt_ram (
		.clok(clok), .we(pt_we), .addr(pt_raddr), .wdata(pt_wdata), .rdata(pt_rdata)
	);

endmodule

//--- dv/clock_gen.sv
`timescale 1ns/1ns

// free running clock plus a reset held low for a fixed number of cycles
module clock_gen #(
	parameter int PERIOD = 100, // ns
	parameter int RESET_CYCLES = 16
)(
	output logic clok,
	output logic resetm
);

	initial begin
		clok = 1'b0;
		forever #(PERIOD / 2) clok = ~clok;
	end

	initial begin
		resetm = 1'b0; // held from time zero
		repeat (RESET_CYCLES) @(posedge clok);
		@(negedge clok);
		resetm = 1'b1; // released away from the active edge
	end

endmodule

//--- dv/tb_rc4_cracker.sv
`timescale 1ns/1ns

module tb_rc4_cracker
	import rc4_pkg::*;
();

	localparam int MSG_LEN = 32;
	localparam int unsigned KEY_LIMIT = 512; // short range for simulation
	localparam int MA = $clog2(MSG_LEN);
	localparam int RUNS = 3; // searches in the sequence below
	localparam longint LIMIT = longint'(RUNS) * KEY_LIMIT * (256 + 768 + 5 * MSG_LEN + 8);

	logic          clok;
	logic          resetm;
	logic          ct_we;
	logic [MA-1:0] ct_addr;
	byte_t         ct_wdata;
	logic          start;
	logic [MA-1:0] pt_addr;
	byte_t         pt_rdata;
	logic          busy;
	logic          found;
	logic          exhausted;
	key_t          key;

	byte_t  pt_model [MSG_LEN]; // chosen plaintext
	byte_t  ct_model [MSG_LEN]; // what the dut gets
	byte_t  ks_model [MSG_LEN]; // keystream of the last key modelled
	int     key_errs = 0;
	int     byte_errs = 0;
	int     flag_errs = 0;
	longint cycles = 0;

	clock_gen #(.PERIOD(100), .RESET_CYCLES(16)) u_clk (.clok(clok), .resetm(resetm));

	rc4_cracker #(.MSG_LEN(MSG_LEN), .KEY_LIMIT(KEY_LIMIT)) dut (
		.clok(clok), .resetm(resetm),
		.ct_we(ct_we), .ct_addr(ct_addr), .ct_wdata(ct_wdata), .start(start),
		.pt_addr(pt_addr), .pt_rdata(pt_rdata),
		.busy(busy), .found(found), .exhausted(exhausted), .key(key)
	);

	// lower case letter or space
	function automatic bit char_ok(input byte_t b);
		return (b == 8'd32) || ((b >= 8'd97) && (b <= 8'd122));
	endfunction

	// reference rc4: ksa with 3 key bytes msb first, then MSG_LEN prga bytes
	function automatic void make_keystream(input key_t k);
		byte_t s [SBOX_DEPTH];
		byte_t kb [3];
		byte_t tmp;
		int    i;
		int    j;
		kb[0] = k[23:16];
		kb[1] = k[15:8];
		kb[2] = k[7:0];
		for (int n = 0; n < SBOX_DEPTH; n++) begin
			s[n] = byte_t'(n); // identity
		end
		j = 0;
		for (int n = 0; n < SBOX_DEPTH; n++) begin
			j = (j + int'(s[n]) + int'(kb[n % 3])) % 256;
			tmp = s[n];
			s[n] = s[j];
			s[j] = tmp;
		end
		i = 0;
		j = 0;
		for (int n = 0; n < MSG_LEN; n++) begin
			i = (i + 1) % 256;
			j = (j + int'(s[i])) % 256;
			tmp = s[i];
			s[i] = s[j];
			s[j] = tmp;
			ks_model[n] = s[(int'(s[i]) + int'(s[j])) % 256];
		end
	endfunction

	// lowest key in range that decodes ct_model to text, -1 if none
	function automatic int first_pass_key();
		bit ok;
		for (int k = 0; k < KEY_LIMIT; k++) begin
			make_keystream(key_t'(k));
			ok = 1'b1;
			for (int n = 0; (n < MSG_LEN) && ok; n++) begin
				ok = char_ok(ct_model[n] ^ ks_model[n]); // stop at first bad byte
			end
			if (ok) begin
				return k;
			end
		end
		return -1;
	endfunction

	task automatic check_key(input string name, input key_t exp, input key_t act);
		if (act !== exp) begin
			key_errs++;
			$display("[ERROR] %0t ns %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp) begin
			byte_errs++;
			$display("[ERROR] %0t ns %s expected %02h actual %02h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input bit exp, input logic act);
		if (act !== exp) begin
			flag_errs++;
			$display("[ERROR] %0t ns %s expected %0b actual %0b", $time, name, exp, act);
		end
	endtask

	// one full search: build message, load, start, wait, check outcome
	task automatic run_search(input bit no_key, input bit noise);
		key_t used;
		int   exp_key;
		int   r;
		for (int n = 0; n < MSG_LEN; n++) begin
			r = $urandom_range(0, 26);
			pt_model[n] = (r == 26) ? 8'd32 : byte_t'(97 + r); // 26 maps to space
		end
		do begin
			if (no_key) begin
				used = key_t'($urandom_range(KEY_LIMIT, (1 << KEY_W) - 1)); // out of range
			end else begin
				used = key_t'($urandom_range(0, KEY_LIMIT - 1));
			end
			make_keystream(used);
			for (int n = 0; n < MSG_LEN; n++) begin
				ct_model[n] = pt_model[n] ^ ks_model[n];
			end
			exp_key = first_pass_key(); // may be below used
		end while (no_key && (exp_key >= 0));
		for (int n = 0; n < MSG_LEN; n++) begin
			@(negedge clok);
			ct_we = 1'b1;
			ct_addr = MA'(n);
			ct_wdata = ct_model[n];
		end
		@(negedge clok);
		ct_we = 1'b0;
		start = 1'b1;
		@(negedge clok);
		start = 1'b0;
		check_flag("busy", 1'b1, busy);
		if (noise) begin
			repeat (8) begin // junk loads and restarts mid search
				@(negedge clok);
				ct_we = 1'b1;
				ct_addr = MA'($urandom_range(0, MSG_LEN - 1));
				ct_wdata = byte_t'($urandom);
				start = 1'($urandom_range(0, 1));
			end
			@(negedge clok);
			ct_we = 1'b0;
			start = 1'b0;
		end
		while (!(found || exhausted)) begin
			@(negedge clok);
		end
		check_flag("busy", 1'b0, busy); // falls with the result
		if (exp_key >= 0) begin
			check_flag("found", 1'b1, found);
			check_flag("exhausted", 1'b0, exhausted);
			check_key("key", key_t'(exp_key), key);
			make_keystream(key_t'(exp_key));
			for (int n = 0; n < MSG_LEN; n++) begin
				@(negedge clok);
				pt_addr = MA'(n);
				@(negedge clok); // one cycle read latency
				check_byte($sformatf("pt_rdata[%0d]", n), ct_model[n] ^ ks_model[n], pt_rdata);
			end
		end else begin
			check_flag("found", 1'b0, found);
			check_flag("exhausted", 1'b1, exhausted);
			check_key("key", key_t'(KEY_LIMIT - 1), key); // last key tried
		end
	endtask

	// global watchdog
	always @(posedge clok) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: no search result after %0d cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		ct_we = 1'b0;
		ct_addr = '0;
		ct_wdata = '0;
		start = 1'b0;
		pt_addr = '0;
		void'($urandom(32'hc2a8)); // single seed for the run
		@(posedge resetm);
		@(negedge clok);
		check_flag("busy", 1'b0, busy);
		check_flag("found", 1'b0, found);
		check_flag("exhausted", 1'b0, exhausted);
		check_key("key", '0, key);
		run_search(1'b0, 1'b1); // key in range, noise while busy
		run_search(1'b1, 1'b0); // no key decodes
		run_search(1'b0, 1'b0); // restart after completion
		$display("errors: key %0d, byte %0d, flag %0d, total %0d",
			key_errs, byte_errs, flag_errs, key_errs + byte_errs + flag_errs);
		if ((key_errs + byte_errs + flag_errs) == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- project.f
hdl/rc4_pkg.sv
hdl/byte_ram.sv
hdl/sbox_init.sv
hdl/key_schedule.sv
hdl/stream_decrypt.sv
hdl/key_search_ctrl.sv
hdl/rc4_cracker.sv
dv/clock_gen.sv
dv/tb_rc4_cracker.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rc4_cracker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rc4_cracker -f project.f -o sim_rc4

./obj_dir/sim_rc4 > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
